//--- compile.f
oc_pkg.sv
oc_mm_if.sv
oc_csr.sv
oc_sequencer.sv
oc_bus_acq.sv
oc_top.sv
oc_checker.sv
tb_oc_top.sv

//--- oc_bus_acq.sv
// commands reach the basic block only while the fabric grant is held; ownership drops with mutex_req
`timescale 1ns/1ps
`include "oc_defines.svh"

module oc_bus_acq
  import oc_pkg::*;
(
  input  logic                  reconfig_clk,
  input  logic                  reset,
  oc_mm_if.slave                bus,
  input  logic                  base_waitrequest,
  input  logic [`OC_DATA_W-1:0] base_readdata,
  input  logic                  arb_grant,
  output logic [`OC_ADDR_W-1:0] base_address,
  output logic [`OC_DATA_W-1:0] base_writedata,
  output logic                  base_write,
  output logic                  base_read,
  output logic                  arb_req
);

  logic    granted;  // grant seen for a full cycle while requesting
  logic    owned;
  oc_cmd_t gated;    // command after ownership gating

  assign arb_req = bus.mutex_req;  // already registered in the sequencer

  always_ff @(posedge reconfig_clk or posedge reset) begin
    if (reset) begin
      granted <= 1'b0;
    end else begin
      granted <= bus.mutex_req & arb_grant;  // clears as soon as the request drops
    end
  end

  // live grant too, so a withdrawn grant stops strobes in the same cycle
  assign owned = granted & arb_grant & bus.mutex_req;

  always_comb begin
    gated       = bus.cmd;
    gated.write = bus.cmd.write & owned;
    gated.read  = bus.cmd.read & owned;
  end

  assign base_address   = gated.address;
  assign base_writedata = gated.writedata;
  assign base_write     = gated.write;
  assign base_read      = gated.read;

  // sequencer stalls until owned, then sees the basic block's own back-pressure
  assign bus.waitrequest = ~owned | base_waitrequest;
  assign bus.readdata    = base_readdata;

endmodule

//--- oc_checker.sv
// bus protocol checks bound into oc_top; they are disabled while reset is high and count failures for the testbench
`timescale 1ns/1ps
`include "oc_defines.svh"

module oc_checker
  import oc_pkg::*;
(
  input logic                      reconfig_clk,
  input logic                      reset,
  input logic [`OC_CSR_ADDR_W-1:0] oc_address,
  input logic [`OC_DATA_W-1:0]     oc_writedata,
  input logic                      oc_write,
  input logic                      base_write,
  input logic                      base_read,
  input logic                      arb_grant,
  input logic                      arb_req,
  input logic                      cal_start,
  input oc_cmd_t                   cmd,          // sequencer side, before gating
  input logic                      waitrequest
);

  int unsigned fail_cnt = 0;  // read by the testbench monitor
  logic        start_wr;      // status write with the start bit set

  assign start_wr = oc_write && (oc_address == `OC_CSR_STATUS_ADDR) &&
                    oc_writedata[`OC_CSR_START_BIT];

  ////////////////////////////////////////
  // basic bus
  ////////////////////////////////////////
  a_one_strobe: assert property (@(posedge reconfig_clk) disable iff (reset)
    !(base_write && base_read) && !(cmd.write && cmd.read))
    else begin
      $error("write and read strobes high together");
      fail_cnt++;
    end

  // no strobe without a grant held since the cycle before
  a_grant_held: assert property (@(posedge reconfig_clk) disable iff (reset)
    (base_write || base_read) |-> arb_grant && $past(arb_grant && arb_req))
    else begin
      $error("base strobe without arb_grant");
      fail_cnt++;
    end

  a_cmd_stable: assert property (@(posedge reconfig_clk) disable iff (reset)
    ((cmd.write || cmd.read) && waitrequest) |=> $stable(cmd))
    else begin
      $error("command changed while waitrequest was high");
      fail_cnt++;
    end

  // start comes one cycle after a start write, a write right behind another adds none
  a_start_pulse: assert property (@(posedge reconfig_clk) disable iff (reset)
    cal_start |-> $past(start_wr) && !$past(start_wr, 2))
    else begin
      $error("cal_start without a single preceding start write");
      fail_cnt++;
    end

endmodule

bind oc_top oc_checker chk_i (
  .reconfig_clk (reconfig_clk),
  .reset        (reset),
  .oc_address   (oc_address),
  .oc_writedata (oc_writedata),
  .oc_write     (oc_write),
  .base_write   (base_write),
  .base_read    (base_read),
  .arb_grant    (arb_grant),
  .arb_req      (arb_req),
  .cal_start    (cal_start),
  .cmd          (mm_if.cmd),
  .waitrequest  (mm_if.waitrequest)
);

//--- oc_csr.sv
// status register at address 2 only; reads answer one cycle later without waitrequest, done flag survives reset
`timescale 1ns/1ps
`include "oc_defines.svh"

module oc_csr (
  input  logic                      reconfig_clk,
  input  logic                      reset,
  input  logic [`OC_CSR_ADDR_W-1:0] oc_address,
  input  logic [`OC_DATA_W-1:0]     oc_writedata,
  input  logic                      oc_write,
  input  logic                      oc_read,
  input  logic                      cal_busy,
  input  logic                      seq_idle,
  output logic [`OC_DATA_W-1:0]     oc_readdata,
  output logic                      cal_start,
  output logic                      oc_done
);

  logic                  start_q;          // start bit as written
  logic                  start_d;          // one cycle behind, for the edge
  logic                  has_run = 1'b0;   // set once the engine has been busy
  logic                  status_hit;
  logic [`OC_DATA_W-1:0] status_word;

  assign status_hit = (oc_address == `OC_CSR_STATUS_ADDR);

  always_comb begin
    status_word = '0;
    status_word[`OC_CSR_BUSY_BIT] = cal_busy;  // all other bits read zero
  end

  always_ff @(posedge reconfig_clk or posedge reset) begin
    if (reset) begin
      oc_readdata <= '0;
      start_q     <= 1'b0;
      start_d     <= 1'b0;
    end else begin
      start_d <= start_q;
      if (oc_read) begin
        if (status_hit) oc_readdata <= status_word;
      end else if (oc_write) begin
        if (status_hit) start_q <= oc_writedata[`OC_CSR_START_BIT];
      end else begin
        start_q <= 1'b0;  // idle bus cycle clears start
      end
    end
  end

  assign cal_start = start_q & ~start_d;  // rising edge only, back-to-back writes give one pulse

  // calibration runs once at power-up, so a later reset must not drop done
  always_ff @(posedge reconfig_clk) begin
    if (!has_run) has_run <= cal_busy;
  end

  // idle check covers the release series that runs after busy falls
  assign oc_done = has_run & ~cal_busy & seq_idle;

endmodule

//--- oc_defines.svh
// widths and basic-bus encodings for the offset-cancellation bridge; control words assume the basic block's direct-access map
`ifndef OC_DEFINES_SVH
`define OC_DEFINES_SVH

// bus widths
`define OC_ADDR_W      3   // basic reconfiguration bus address
`define OC_DATA_W      32  // basic bus and csr data
`define OC_DPRIO_W     16  // calibration register data
`define OC_REMAP_W     12  // remapped physical address
`define OC_LCH_W       11  // quad address (9) plus channel bits (2)
`define OC_CSR_ADDR_W  3

////////////////////////////////////////
// basic block register map
////////////////////////////////////////
`define OC_BASIC_LOGICAL   3'd0  // logical channel number
`define OC_BASIC_PHYSICAL  3'd1  // physical channel, read only
`define OC_BASIC_CONTROL   3'd2  // control and status word
`define OC_BASIC_OFFSET    3'd3  // indirect register offset
`define OC_BASIC_DATA      3'd4  // indirect register data

// control words written to OC_BASIC_CONTROL
`define OC_CTRL_WRITE           32'h0000_0001
`define OC_CTRL_READ            32'h0000_0002
`define OC_CTRL_INTERNAL_WRITE  32'h0000_0005  // test-bus select is an internal register
`define OC_CTRL_LOCK_SET        32'h0000_0010  // request the physical lock, status bit 0 shows it
`define OC_CTRL_LOCK_CLEAR      32'h0000_0020

// soft registers behind the indirect offset
`define OC_RSTCTL_OFFSET       32'h0000_0011
`define OC_RSTCTL_OVR_VALUE    32'h0000_0003  // rx reset override plus analog reset released
`define OC_CALEN_OFFSET        32'h0000_0014
`define OC_CALEN_MASK          32'h0000_0001
`define OC_TESTBUS_SEL_OFFSET  32'h0000_0003
`define OC_TESTBUS_OC_VALUE    32'h0000_0006  // test bus six carries the comparator outputs

`define OC_ILLEGAL_PHYS  3'b111  // low bits all ones, no physical channel behind it

// csr map
`define OC_CSR_STATUS_ADDR  3'd2
`define OC_CSR_START_BIT    0
`define OC_CSR_BUSY_BIT     8

`endif

//--- oc_mm_if.sv
// sequencer to bus-acquisition link; a command with a strobe stays unchanged until waitrequest is low
`timescale 1ns/1ps
`include "oc_defines.svh"

interface oc_mm_if
  import oc_pkg::*;
();

  oc_cmd_t               cmd;          // address, data and strobes
  logic                  mutex_req;    // level, held while the bus is owned
  logic                  waitrequest;  // high also while the fabric grant is missing
  logic [`OC_DATA_W-1:0] readdata;     // valid in the accepting cycle

  modport master (
    output cmd,
    output mutex_req,
    input  waitrequest,
    input  readdata
  );

  modport slave (
    input  cmd,
    input  mutex_req,
    output waitrequest,
    output readdata
  );

endinterface

//--- oc_pkg.sv
// types shared by the sequencer, the bus interface and bus acquisition; state encodings are fixed at 5 bits
`include "oc_defines.svh"

package oc_pkg;

  // one command on the basic bus, held until accepted
  typedef struct packed {
    logic [`OC_ADDR_W-1:0] address;
    logic [`OC_DATA_W-1:0] writedata;
    logic                  write;
    logic                  read;
  } oc_cmd_t;

  // each bus state holds the command that was set when it was entered
  typedef enum logic [4:0] {
    ST_IDLE,            // no engine activity
    ST_START,           // issue logical channel write
    ST_LOGICAL,
    ST_READ_PHY,
    ST_CHECK_PHY,       // decide illegal, lock or access
    ST_LOCK_SET,
    ST_LOCK_READ,
    ST_CHECK_LOCK,
    ST_RST_OFS,         // rx analog reset override
    ST_RST_DATA,
    ST_RST_CTRL,
    ST_TB_OFS,          // test-bus select
    ST_TB_DATA,
    ST_TB_CTRL,
    ST_CALEN_OFS,       // calibration enable
    ST_CALEN_DATA,
    ST_CALEN_CTRL,
    ST_ACC_OFS,         // the access itself
    ST_ACC_DATA,
    ST_ACC_CTRL,
    ST_WRITE_DONE,
    ST_RD_DATA,
    ST_WAIT_NEXT,       // lock held, waiting on the engine
    ST_REL_LOCK,        // release series
    ST_REL_RST_OFS,
    ST_REL_RST_DATA,
    ST_REL_RST_CTRL,
    ST_REL_CALEN_OFS,
    ST_REL_CALEN_DATA,
    ST_REL_CALEN_CTRL
  } oc_state_t;

endpackage

//--- oc_sequencer.sv
// one engine access at a time; a request is taken only in idle or while waiting, and a channel change is served after release
`timescale 1ns/1ps
`include "oc_defines.svh"

module oc_sequencer
  import oc_pkg::*;
(
  input  logic                      reconfig_clk,
  input  logic                      reset,
  input  logic                      cal_busy,
  input  logic [`OC_DPRIO_W-1:0]    cal_dprio_addr,
  input  logic [`OC_LCH_W-3:0]      cal_quad_addr,
  input  logic [`OC_DPRIO_W-1:0]    cal_dprio_dataout,
  input  logic                      cal_dprio_wren,
  input  logic                      cal_dprio_rden,
  output logic [`OC_DPRIO_W-1:0]    cal_dprio_datain,
  output logic                      cal_dprio_busy,
  output logic [`OC_REMAP_W-1:0]    cal_remap_addr,
  output logic                      seq_idle,
  oc_mm_if.master                   bus
);

  localparam int      OFS_W    = 15;   // dprio offset bits passed to the basic block
  localparam oc_cmd_t CMD_NONE = '0;   // strobes low

  oc_state_t               state;
  oc_cmd_t                 cmd;
  logic                    mutex_req;
  logic                    locked;     // physical lock held
  logic                    pending;    // request waiting behind a release series
  logic                    is_write;   // 1 write, 0 read
  logic [`OC_LCH_W-1:0]    req_chan;   // latched request
  logic [OFS_W-1:0]        req_ofs;
  logic [`OC_DPRIO_W-1:0]  req_data;
  logic [`OC_REMAP_W-1:0]  rd_q;       // last read result
  logic                    acc;
  logic                    new_req;
  logic                    take_req;
  logic                    chan_diff;

  function automatic oc_cmd_t wr(input logic [`OC_ADDR_W-1:0] a, input logic [`OC_DATA_W-1:0] d);
    oc_cmd_t c;
    c           = CMD_NONE;
    c.address   = a;
    c.writedata = d;
    c.write     = 1'b1;
    return c;
  endfunction

  function automatic oc_cmd_t rd(input logic [`OC_ADDR_W-1:0] a);
    oc_cmd_t c;
    c         = CMD_NONE;
    c.address = a;
    c.read    = 1'b1;
    return c;
  endfunction

  assign acc       = ~bus.waitrequest;                 // only looked at with a strobe held
  assign new_req   = cal_dprio_wren | cal_dprio_rden;  // engine never raises both
  assign take_req  = new_req & ((state == ST_IDLE) | ((state == ST_WAIT_NEXT) & cal_busy));
  assign chan_diff = ({cal_quad_addr, cal_dprio_addr[13:12]} != req_chan);
  assign seq_idle  = (state == ST_IDLE);

  assign bus.cmd       = cmd;
  assign bus.mutex_req = mutex_req;

  // request payload and read results
  always_ff @(posedge reconfig_clk) begin
    if (take_req) begin
      req_chan <= {cal_quad_addr, cal_dprio_addr[13:12]};
      req_ofs  <= cal_dprio_addr[OFS_W-1:0];
      req_data <= cal_dprio_dataout;
    end
    if (cmd.read && acc) rd_q <= bus.readdata[`OC_REMAP_W-1:0];
    if (state == ST_RD_DATA && acc) cal_dprio_datain <= bus.readdata[`OC_DPRIO_W-1:0];
  end

  ////////////////////////////////////////
  // command series
  ////////////////////////////////////////
  always_ff @(posedge reconfig_clk or posedge reset) begin
    if (reset) begin
      state          <= ST_IDLE;
      cmd            <= CMD_NONE;
      mutex_req      <= 1'b0;
      locked         <= 1'b0;
      pending        <= 1'b0;
      is_write       <= 1'b0;
      cal_dprio_busy <= 1'b0;
      cal_remap_addr <= '0;
    end else begin
      mutex_req <= ~((state == ST_IDLE) & ~cal_busy);  // keep ownership until fully released
      if (take_req) is_write <= cal_dprio_wren;
      case (state)
        ST_IDLE: if (new_req) state <= ST_START;
        ST_START: begin
          cmd   <= wr(`OC_BASIC_LOGICAL, {{(`OC_DATA_W-`OC_LCH_W){1'b0}}, req_chan});
          state <= ST_LOGICAL;
        end
        ST_LOGICAL:  if (acc) begin cmd <= rd(`OC_BASIC_PHYSICAL); state <= ST_READ_PHY; end
        ST_READ_PHY: if (acc) begin cmd <= CMD_NONE; state <= ST_CHECK_PHY; end
        ST_CHECK_PHY: begin
          if (rd_q[2:0] == `OC_ILLEGAL_PHYS) begin
            cal_remap_addr <= '1;  // tells the engine the channel is absent
            state          <= ST_IDLE;
          end else begin
            cal_remap_addr <= rd_q;
            if (locked) begin  // lock and overrides already in place
              cmd   <= wr(`OC_BASIC_OFFSET, {{(`OC_DATA_W-OFS_W){1'b0}}, req_ofs});
              state <= ST_ACC_OFS;
            end else begin
              cmd   <= wr(`OC_BASIC_CONTROL, `OC_CTRL_LOCK_SET);
              state <= ST_LOCK_SET;
            end
          end
        end
        ST_LOCK_SET:  if (acc) begin cmd <= rd(`OC_BASIC_CONTROL); state <= ST_LOCK_READ; end
        ST_LOCK_READ: if (acc) begin cmd <= CMD_NONE; state <= ST_CHECK_LOCK; end
        ST_CHECK_LOCK: begin
          if (rd_q[0]) begin
            locked <= 1'b1;
            cmd    <= wr(`OC_BASIC_OFFSET, `OC_RSTCTL_OFFSET);
            state  <= ST_RST_OFS;
          end else begin  // denied, ask again
            cmd   <= wr(`OC_BASIC_CONTROL, `OC_CTRL_LOCK_SET);
            state <= ST_LOCK_SET;
          end
        end
        ST_RST_OFS:  if (acc) begin cmd <= wr(`OC_BASIC_DATA, `OC_RSTCTL_OVR_VALUE); state <= ST_RST_DATA; end
        ST_RST_DATA: if (acc) begin cmd <= wr(`OC_BASIC_CONTROL, `OC_CTRL_WRITE); state <= ST_RST_CTRL; end
        ST_RST_CTRL: if (acc) begin cmd <= wr(`OC_BASIC_OFFSET, `OC_TESTBUS_SEL_OFFSET); state <= ST_TB_OFS; end
        ST_TB_OFS:   if (acc) begin cmd <= wr(`OC_BASIC_DATA, `OC_TESTBUS_OC_VALUE); state <= ST_TB_DATA; end
        ST_TB_DATA:  if (acc) begin cmd <= wr(`OC_BASIC_CONTROL, `OC_CTRL_INTERNAL_WRITE); state <= ST_TB_CTRL; end
        ST_TB_CTRL:  if (acc) begin cmd <= wr(`OC_BASIC_OFFSET, `OC_CALEN_OFFSET); state <= ST_CALEN_OFS; end
        ST_CALEN_OFS:  if (acc) begin cmd <= wr(`OC_BASIC_DATA, `OC_CALEN_MASK); state <= ST_CALEN_DATA; end
        ST_CALEN_DATA: if (acc) begin cmd <= wr(`OC_BASIC_CONTROL, `OC_CTRL_WRITE); state <= ST_CALEN_CTRL; end
        ST_CALEN_CTRL: if (acc) begin
          cmd   <= wr(`OC_BASIC_OFFSET, {{(`OC_DATA_W-OFS_W){1'b0}}, req_ofs});
          state <= ST_ACC_OFS;
        end
        ST_ACC_OFS: if (acc) begin
          if (is_write) begin
            cmd   <= wr(`OC_BASIC_DATA, {{(`OC_DATA_W-`OC_DPRIO_W){1'b0}}, req_data});
            state <= ST_ACC_DATA;
          end else begin
            cmd   <= wr(`OC_BASIC_CONTROL, `OC_CTRL_READ);
            state <= ST_ACC_CTRL;
          end
        end
        ST_ACC_DATA: if (acc) begin cmd <= wr(`OC_BASIC_CONTROL, `OC_CTRL_WRITE); state <= ST_ACC_CTRL; end
        ST_ACC_CTRL: if (acc) begin
          cal_dprio_busy <= 1'b1;  // access accepted by the basic block
          cmd            <= is_write ? CMD_NONE : rd(`OC_BASIC_DATA);
          state          <= is_write ? ST_WRITE_DONE : ST_RD_DATA;
        end
        ST_WRITE_DONE: begin cal_dprio_busy <= 1'b0; state <= ST_WAIT_NEXT; end
        ST_RD_DATA: if (acc) begin  // datain loads on this same edge
          cal_dprio_busy <= 1'b0;
          cmd            <= CMD_NONE;
          state          <= ST_WAIT_NEXT;
        end
        ST_WAIT_NEXT: begin
          if (!cal_busy || (new_req && chan_diff)) begin
            pending <= cal_busy;  // channel change, serve it after release
            cmd     <= wr(`OC_BASIC_CONTROL, `OC_CTRL_LOCK_CLEAR);
            state   <= ST_REL_LOCK;
          end else if (new_req) begin
            state <= ST_START;  // same channel, overrides still set
          end
        end
        ST_REL_LOCK: if (acc) begin
          locked <= 1'b0;
          cmd    <= wr(`OC_BASIC_OFFSET, `OC_RSTCTL_OFFSET);
          state  <= ST_REL_RST_OFS;
        end
        ST_REL_RST_OFS:  if (acc) begin cmd <= wr(`OC_BASIC_DATA, '0); state <= ST_REL_RST_DATA; end
        ST_REL_RST_DATA: if (acc) begin cmd <= wr(`OC_BASIC_CONTROL, `OC_CTRL_WRITE); state <= ST_REL_RST_CTRL; end
        ST_REL_RST_CTRL: if (acc) begin cmd <= wr(`OC_BASIC_OFFSET, `OC_CALEN_OFFSET); state <= ST_REL_CALEN_OFS; end
        ST_REL_CALEN_OFS:  if (acc) begin cmd <= wr(`OC_BASIC_DATA, '0); state <= ST_REL_CALEN_DATA; end
        ST_REL_CALEN_DATA: if (acc) begin cmd <= wr(`OC_BASIC_CONTROL, `OC_CTRL_WRITE); state <= ST_REL_CALEN_CTRL; end
        ST_REL_CALEN_CTRL: if (acc) begin
          cmd     <= CMD_NONE;
          pending <= 1'b0;
          state   <= pending ? ST_START : ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- oc_top.sv
// bridge top; the calibration engine and the fabric arbiter sit outside and connect through plain ports
`timescale 1ns/1ps
`include "oc_defines.svh"

module oc_top (
  input  logic                      reconfig_clk,
  input  logic                      reset,
  // csr slave
  input  logic [`OC_CSR_ADDR_W-1:0] oc_address,
  input  logic [`OC_DATA_W-1:0]     oc_writedata,
  input  logic                      oc_write,
  input  logic                      oc_read,
  output logic [`OC_DATA_W-1:0]     oc_readdata,
  output logic                      oc_done,
  // calibration engine
  output logic                      cal_start,
  input  logic                      cal_busy,
  input  logic [`OC_DPRIO_W-1:0]    cal_dprio_addr,
  input  logic [`OC_LCH_W-3:0]      cal_quad_addr,
  input  logic [`OC_DPRIO_W-1:0]    cal_dprio_dataout,
  input  logic                      cal_dprio_wren,
  input  logic                      cal_dprio_rden,
  output logic [`OC_DPRIO_W-1:0]    cal_dprio_datain,
  output logic                      cal_dprio_busy,
  output logic [`OC_REMAP_W-1:0]    cal_remap_addr,
  // basic reconfiguration bus
  output logic [`OC_ADDR_W-1:0]     base_address,
  output logic [`OC_DATA_W-1:0]     base_writedata,
  output logic                      base_write,
  output logic                      base_read,
  input  logic                      base_waitrequest,
  input  logic [`OC_DATA_W-1:0]     base_readdata,
  // fabric arbiter
  output logic                      arb_req,
  input  logic                      arb_grant
);

  logic    seq_idle;  // gates the done flag
  oc_mm_if mm_if ();  // sequencer to bus acquisition

  oc_csr csr_i (
    .reconfig_clk (reconfig_clk),
    .reset        (reset),
    .oc_address   (oc_address),
    .oc_writedata (oc_writedata),
    .oc_write     (oc_write),
    .oc_read      (oc_read),
    .cal_busy     (cal_busy),
    .seq_idle     (seq_idle),
    .oc_readdata  (oc_readdata),
    .cal_start    (cal_start),
    .oc_done      (oc_done)
  );

  oc_sequencer seq_i (
    .reconfig_clk      (reconfig_clk),
    .reset             (reset),
    .cal_busy          (cal_busy),
    .cal_dprio_addr    (cal_dprio_addr),
    .cal_quad_addr     (cal_quad_addr),
    .cal_dprio_dataout (cal_dprio_dataout),
    .cal_dprio_wren    (cal_dprio_wren),
    .cal_dprio_rden    (cal_dprio_rden),
    .cal_dprio_datain  (cal_dprio_datain),
    .cal_dprio_busy    (cal_dprio_busy),
    .cal_remap_addr    (cal_remap_addr),
    .seq_idle          (seq_idle),
    .bus               (mm_if)
  );

  oc_bus_acq acq_i (
    .reconfig_clk     (reconfig_clk),
    .reset            (reset),
    .bus              (mm_if),
    .base_waitrequest (base_waitrequest),
    .base_readdata    (base_readdata),
    .arb_grant        (arb_grant),
    .base_address     (base_address),
    .base_writedata   (base_writedata),
    .base_write       (base_write),
    .base_read        (base_read),
    .arb_req          (arb_req)
  );

endmodule

//--- tb_oc_top.sv
// testbench for oc_top; models the calibration engine, the arbiter and the basic block, and expects every bus command in order
`timescale 1ns/1ps
`include "oc_defines.svh"

module tb_oc_top;

  localparam logic [31:0] DATA_PAT = 32'h3C5A_9E17;  // modeled data register

  logic reconfig_clk = 1'b0;
  logic reset;
  logic [`OC_CSR_ADDR_W-1:0] oc_address;
  logic [`OC_DATA_W-1:0] oc_writedata, oc_readdata, base_writedata, base_readdata;
  logic oc_write, oc_read, oc_done, cal_start, cal_busy, cal_dprio_wren, cal_dprio_rden;
  logic [`OC_DPRIO_W-1:0] cal_dprio_addr, cal_dprio_dataout, cal_dprio_datain;
  logic [`OC_LCH_W-3:0] cal_quad_addr;
  logic cal_dprio_busy, base_write, base_read, base_waitrequest, arb_req, arb_grant;
  logic [`OC_REMAP_W-1:0] cal_remap_addr, phys_val;
  logic [`OC_ADDR_W-1:0] base_address;
  logic [35:0] exp_q[$];  // {address, writedata, write}
  integer seed;
  int lock_reads = 0;     // control reads since the last lock release
  int gdelay = 0;
  logic grant_hold = 1'b0;

  oc_top dut_i (.*);

  always #4 reconfig_clk = ~reconfig_clk;

  task automatic fail_now(input string why);
    $display("%0t %s", $time, why);
    $display("sim failed");
    $fatal(1, "run stopped");
  endtask

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    $display("sim failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic tick(input int n);
    repeat (n) @(negedge reconfig_clk);
  endtask

  task automatic push(input logic [2:0] a, input logic [31:0] d, input logic we);
    exp_q.push_back({a, d, we});
  endtask

  task automatic expect_head(input logic [8:0] quad, input logic [15:0] addr);
    push(`OC_BASIC_LOGICAL, {21'h0, quad, addr[13:12]}, 1'b1);
    push(`OC_BASIC_PHYSICAL, 32'h0, 1'b0);
  endtask

  task automatic expect_setup;
    repeat (2) begin  // first lock attempt is denied by the model
      push(`OC_BASIC_CONTROL, `OC_CTRL_LOCK_SET, 1'b1);
      push(`OC_BASIC_CONTROL, 32'h0, 1'b0);
    end
    push(`OC_BASIC_OFFSET, `OC_RSTCTL_OFFSET, 1'b1);
    push(`OC_BASIC_DATA, `OC_RSTCTL_OVR_VALUE, 1'b1);
    push(`OC_BASIC_CONTROL, `OC_CTRL_WRITE, 1'b1);
    push(`OC_BASIC_OFFSET, `OC_TESTBUS_SEL_OFFSET, 1'b1);
    push(`OC_BASIC_DATA, `OC_TESTBUS_OC_VALUE, 1'b1);
    push(`OC_BASIC_CONTROL, `OC_CTRL_INTERNAL_WRITE, 1'b1);
    push(`OC_BASIC_OFFSET, `OC_CALEN_OFFSET, 1'b1);
    push(`OC_BASIC_DATA, `OC_CALEN_MASK, 1'b1);
    push(`OC_BASIC_CONTROL, `OC_CTRL_WRITE, 1'b1);
  endtask

  task automatic expect_access(input logic we, input logic [15:0] addr, input logic [15:0] d);
    push(`OC_BASIC_OFFSET, {17'h0, addr[14:0]}, 1'b1);
    if (we) push(`OC_BASIC_DATA, {16'h0, d}, 1'b1);
    push(`OC_BASIC_CONTROL, we ? `OC_CTRL_WRITE : `OC_CTRL_READ, 1'b1);
    if (!we) push(`OC_BASIC_DATA, 32'h0, 1'b0);
  endtask

  task automatic expect_release;
    push(`OC_BASIC_CONTROL, `OC_CTRL_LOCK_CLEAR, 1'b1);
    push(`OC_BASIC_OFFSET, `OC_RSTCTL_OFFSET, 1'b1);
    push(`OC_BASIC_DATA, 32'h0, 1'b1);
    push(`OC_BASIC_CONTROL, `OC_CTRL_WRITE, 1'b1);
    push(`OC_BASIC_OFFSET, `OC_CALEN_OFFSET, 1'b1);
    push(`OC_BASIC_DATA, 32'h0, 1'b1);
    push(`OC_BASIC_CONTROL, `OC_CTRL_WRITE, 1'b1);
  endtask

  task automatic csr_busy_read(input logic exp_busy);
    oc_address = `OC_CSR_STATUS_ADDR;
    oc_read    = 1'b1;
    tick(1);  // readdata registered on the edge before
    assert (oc_readdata[`OC_CSR_BUSY_BIT] == exp_busy)
      else mismatch("oc_readdata[8]", exp_busy, oc_readdata[`OC_CSR_BUSY_BIT]);
    oc_read = 1'b0;
  endtask

  task automatic start_write(input logic [2:0] a, input logic [31:0] d, input int exp_n);
    int n;
    n = 0;
    oc_address   = a;
    oc_writedata = d;
    oc_write     = 1'b1;  // two writes back to back
    for (int i = 0; i < 6; i++) begin
      tick(1);
      if (cal_start) n++;
      if (i == 1) oc_write = 1'b0;
    end
    assert (n == exp_n) else mismatch("cal_start pulses", exp_n, n);
  endtask

  // engine model, holds the request until the access is taken
  task automatic issue_access(input logic we, input logic [8:0] quad, input logic [15:0] addr,
                              input logic [15:0] d, input logic illegal);
    int t;
    cal_quad_addr     = quad;
    cal_dprio_addr    = addr;
    cal_dprio_dataout = d;
    cal_dprio_wren    = we;
    cal_dprio_rden    = ~we;
    t = 0;
    while (!(illegal ? (cal_remap_addr == '1) : cal_dprio_busy)) begin
      tick(1);
      if (++t > 400) fail_now("access request never accepted");
    end
    cal_dprio_wren = 1'b0;
    cal_dprio_rden = 1'b0;
    t = 0;
    while (cal_dprio_busy) begin
      tick(1);
      if (++t > 400) fail_now("cal_dprio_busy stuck high");
    end
    if (!we && !illegal)
      assert (cal_dprio_datain == DATA_PAT[15:0])
        else mismatch("cal_dprio_datain", DATA_PAT[15:0], cal_dprio_datain);
    t = 0;
    while (exp_q.size() != 0) begin
      tick(1);
      if (++t > 400) fail_now("expected bus commands never appeared");
    end
  endtask

  // accepted commands against the expected series
  always @(posedge reconfig_clk) begin
    logic [35:0] e;
    if (!reset && (base_write || base_read) && !base_waitrequest) begin
      if (exp_q.size() == 0) fail_now("bus command accepted with none expected");
      e = exp_q.pop_front();
      assert (base_address == e[35:33]) else mismatch("base_address", e[35:33], base_address);
      assert (base_write == e[0]) else mismatch("base_write", e[0], base_write);
      if (e[0]) assert (base_writedata == e[32:1])
        else mismatch("base_writedata", e[32:1], base_writedata);
      if (base_write && base_address == `OC_BASIC_CONTROL &&
          base_writedata == `OC_CTRL_LOCK_CLEAR) lock_reads = 0;  // next lock denied once again
      if (base_read && base_address == `OC_BASIC_CONTROL) lock_reads++;
    end
  end

  // basic block and arbiter models
  always @(negedge reconfig_clk) begin
    base_waitrequest = (($random(seed) & 3) == 0);  // one stall in four
    if (!arb_req) begin
      arb_grant = 1'b0;
      gdelay    = $random(seed) & 3;
    end else if (!grant_hold) begin
      if (gdelay != 0) gdelay--;
      else arb_grant = 1'b1;
    end
    case (base_address)
      `OC_BASIC_PHYSICAL: base_readdata = {20'h0, phys_val};
      `OC_BASIC_CONTROL:  base_readdata = {31'h0, lock_reads != 0};
      `OC_BASIC_DATA:     base_readdata = DATA_PAT;
      default:            base_readdata = 32'h0;
    endcase
    if (dut_i.chk_i.fail_cnt != 0) fail_now("a protocol assertion failed");
  end

  initial begin
    int t;
    seed = 44323;
    reset = 1'b1;
    {oc_address, oc_writedata, oc_write, oc_read, cal_busy} = '0;
    {cal_dprio_addr, cal_quad_addr, cal_dprio_dataout, cal_dprio_wren, cal_dprio_rden} = '0;
    {base_waitrequest, base_readdata, arb_grant} = '0;
    phys_val = 12'h0A7;  // low bits 111, illegal
    repeat (5) @(posedge reconfig_clk);
    tick(1);
    reset = 1'b0;
    assert ({base_write, base_read, arb_req, cal_start, cal_dprio_busy, oc_done} == 6'b0)
      else mismatch("outputs after reset", 0, {base_write, base_read, arb_req, cal_start,
                                               cal_dprio_busy, oc_done});
    assert (cal_remap_addr == 0) else mismatch("cal_remap_addr", 0, cal_remap_addr);
    csr_busy_read(1'b0);
    cal_busy = 1'b1;
    tick(1);
    csr_busy_read(1'b1);
    cal_busy = 1'b0;
    start_write(`OC_CSR_STATUS_ADDR, 32'h1, 1);
    start_write(`OC_CSR_STATUS_ADDR, 32'h0, 0);
    start_write(3'd3, 32'h1, 0);
    // grant withheld, then an illegal channel
    grant_hold = 1'b1;
    cal_busy   = 1'b1;
    expect_head(9'h033, 16'h2040);
    fork
      issue_access(1'b1, 9'h033, 16'h2040, 16'h0, 1'b1);
      begin
        tick(10);
        assert (arb_req) else mismatch("arb_req", 1, arb_req);
        assert (exp_q.size() == 2) else mismatch("commands before grant", 0, 2 - exp_q.size());
        grant_hold = 1'b0;
      end
    join
    phys_val = 12'h0A5;
    expect_head(9'h012, 16'h10C4);
    expect_setup;
    expect_access(1'b1, 16'h10C4, 16'hBEEF);
    issue_access(1'b1, 9'h012, 16'h10C4, 16'hBEEF, 1'b0);
    assert (cal_remap_addr == phys_val) else mismatch("cal_remap_addr", phys_val, cal_remap_addr);
    expect_head(9'h012, 16'h10C8);  // same channel, lock still held
    expect_access(1'b1, 16'h10C8, 16'h1357);
    issue_access(1'b1, 9'h012, 16'h10C8, 16'h1357, 1'b0);
    expect_head(9'h012, 16'h1010);
    expect_access(1'b0, 16'h1010, 16'h0);
    issue_access(1'b0, 9'h012, 16'h1010, 16'h0, 1'b0);
    expect_release;
    cal_busy = 1'b0;
    t = 0;
    while (exp_q.size() != 0 || !oc_done || arb_req) begin
      tick(1);
      if (++t > 400) fail_now("release series did not finish");
    end
    if (dut_i.chk_i.fail_cnt != 0) begin
      $display("sim failed");
      $fatal(1, "a protocol assertion failed");
    end else begin
      $display("sim passed");
      $finish;
    end
  end

endmodule
